// ==== filelist.f ====
+incdir+src
src/cddip_support_pkg.sv
src/rbus_ring_node.sv
src/support_regs.sv
src/event_interrupt.sv
src/cddip_support_top.sv
verif/cddip_support_sva.sv
verif/tb_cddip_support.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -f filelist.f \
  --top-module tb_cddip_support -o sim_tb

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "All checks passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

// ==== src/cddip_support_consts.svh ====
/*
  Decompression support block constants.
  Ring and local address widths, register word offsets, ID words and event count.
*/
`ifndef CDDIP_SUPPORT_CONSTS_SVH
`define CDDIP_SUPPORT_CONSTS_SVH

// ring geometry.
`define N_RBUS_ADDR_BITS 16
`define N_RBUS_DATA_BITS 32

// word offset inside the local window.
`define N_LOCL_ADDR_BITS 3

`define CDDIP_BLKID 16'hcdd1
`define CDDIP_REVID 16'h0001

// error events feeding the interrupt unit.
`define N_INT_BITS 15

// register map, word offsets.
`define REG_BLKID_REVID  3'd0
`define REG_SPARE        3'd1
`define REG_CTL          3'd2
`define REG_IM_AVAILABLE 3'd3
`define REG_IM_CONSUMED  3'd4
`define REG_PIPE_STAT    3'd5
`define REG_INT_STATUS   3'd6
`define REG_INT_MASK     3'd7

`endif

// ==== src/cddip_support_pkg.sv ====
/*
  Decompression support types.
  Ring hop, local request and response, bank flags, control word and event bits.
*/
`default_nettype none

`include "cddip_support_consts.svh"

package cddip_support_pkg;

  typedef struct packed {
    logic [`N_RBUS_ADDR_BITS-1:0] addr;
    logic                         wr_strb;
    logic [`N_RBUS_DATA_BITS-1:0] wr_data;
    logic                         rd_strb;
    logic [`N_RBUS_DATA_BITS-1:0] rd_data;
    logic                         ack;
    logic                         err_ack;
  } rbus_ring_t;

  typedef enum logic [1:0] {
    ACC_NONE  = 2'd0,
    ACC_READ  = 2'd1,
    ACC_WRITE = 2'd2
  } acc_op_e;

  typedef struct packed {
    acc_op_e                      op;
    logic [`N_LOCL_ADDR_BITS-1:0] offset;
    logic [`N_RBUS_DATA_BITS-1:0] wdata;
  } loc_req_t;

  typedef struct packed {
    logic                         ack;
    logic                         err_ack;
    logic [`N_RBUS_DATA_BITS-1:0] rdata;
  } loc_rsp_t;

  typedef struct packed {
    logic bank_hi;
    logic bank_lo;
  } im_bank_t;

  // xpd lands in bits 5:4, htf_bl in bits 1:0.
  typedef struct packed {
    im_bank_t xpd;
    im_bank_t lz77d;
    im_bank_t htf_bl;
  } im_flags_t;

  typedef struct packed {
    logic [29:0] reserved;
    logic        stall_on_error;
    logic        pipe_enable;
  } ctl_t;

  // bit 0 is isf_uncor_ecc, bit 14 is xp10_tlvp.
  typedef struct packed {
    logic xp10_tlvp;
    logic xp10_uncor_ecc;
    logic xp10_bimc;
    logic su_uncor_ecc;
    logic cg_tlvp;
    logic crcc0_tlvp;
    logic crcg0_tlvp;
    logic prefix_attach_tlvp;
    logic osf_tlvp;
    logic osf_uncor_ecc;
    logic isf_sys_stall;
    logic isf_ovfl;
    logic isf_prot_err;
    logic isf_tlvp;
    logic isf_uncor_ecc;
  } int_src_t;

  typedef struct packed {
    logic                   rd;
    logic                   wr;
    logic                   sel_mask;
    logic [`N_INT_BITS-1:0] data;
  } int_req_t;

  typedef struct packed {
    logic                   ack;
    logic [`N_INT_BITS-1:0] data;
  } int_rsp_t;

endpackage

`default_nettype wire

// ==== src/cddip_support_top.sv ====
/*
  Decompression support top.
  Ring node, register file and event interrupt unit.
*/
`timescale 1ns/1ns
`default_nettype none

`include "cddip_support_consts.svh"

module cddip_support_top import cddip_support_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [`N_RBUS_ADDR_BITS-1:0]  i_cfg_start_addr,
  input  wire [`N_RBUS_ADDR_BITS-1:0]  i_cfg_end_addr,
  input  wire rbus_ring_t              i_rbus_ring,
  input  wire im_flags_t               i_im_available,
  input  wire [`N_RBUS_DATA_BITS-1:0]  i_pipe_stat,
  input  wire int_src_t                i_int_src,
  output rbus_ring_t                   o_rbus_ring,
  output im_flags_t                    o_im_consumed,
  output ctl_t                         o_ctl_config,
  output logic                         o_int
);

  loc_req_t loc_req;
  loc_rsp_t loc_rsp;
  int_req_t int_req;
  int_rsp_t int_rsp;

  rbus_ring_node u_ring_node (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_cfg_start_addr (i_cfg_start_addr),
    .i_cfg_end_addr   (i_cfg_end_addr),
    .i_rbus_ring      (i_rbus_ring),
    .i_loc_rsp        (loc_rsp),
    .o_rbus_ring      (o_rbus_ring),
    .o_loc_req        (loc_req)
  );

  support_regs u_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .i_loc_req      (loc_req),
    .i_im_available (i_im_available),
    .i_pipe_stat    (i_pipe_stat),
    .i_int_rsp      (int_rsp),
    .o_loc_rsp      (loc_rsp),
    .o_im_consumed  (o_im_consumed),
    .o_ctl_config   (o_ctl_config),
    .o_int_req      (int_req)
  );

  event_interrupt u_event_int (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_int_src (i_int_src),
    .i_int_req (int_req),
    .o_int_rsp (int_rsp),
    .o_int     (o_int)
  );

endmodule

`default_nettype wire

// ==== src/event_interrupt.sv ====
/*
  Event interrupt unit.
  Sticky status with write-1-to-clear, a mask register and one registered
  interrupt line for any unmasked event.
*/
`timescale 1ns/1ns
`default_nettype none

`include "cddip_support_consts.svh"

module event_interrupt import cddip_support_pkg::*; (
  input  wire            clk,
  input  wire            rst_n,
  input  wire int_src_t  i_int_src,
  input  wire int_req_t  i_int_req,
  output int_rsp_t       o_int_rsp,
  output logic           o_int
);

  logic [`N_INT_BITS-1:0] status_q;
  logic [`N_INT_BITS-1:0] mask_q;
  logic [`N_INT_BITS-1:0] clr;

  always_comb begin
    clr            = (i_int_req.wr && !i_int_req.sel_mask) ? i_int_req.data : '0;
    o_int_rsp.ack  = i_int_req.rd || i_int_req.wr;
    o_int_rsp.data = i_int_req.sel_mask ? mask_q : status_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
      mask_q   <= '0;
      o_int    <= 1'b0;
    end else begin
      // a new event beats a clear of the same bit.
      status_q <= (status_q & ~clr) | i_int_src;
      if (i_int_req.wr && i_int_req.sel_mask) begin
        mask_q <= i_int_req.data;
      end
      o_int <= |(status_q & ~mask_q);
    end
  end

endmodule

`default_nettype wire

// ==== src/rbus_ring_node.sv ====
/*
  Register ring node.
  Forwards every hop one cycle later, claims requests in its window and
  merges the local response into the outgoing hop.
*/
`timescale 1ns/1ns
`default_nettype none

`include "cddip_support_consts.svh"

module rbus_ring_node import cddip_support_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire [`N_RBUS_ADDR_BITS-1:0]  i_cfg_start_addr,
  input  wire [`N_RBUS_ADDR_BITS-1:0]  i_cfg_end_addr,
  input  wire rbus_ring_t              i_rbus_ring,
  input  wire loc_rsp_t                i_loc_rsp,
  output rbus_ring_t                   o_rbus_ring,
  output loc_req_t                     o_loc_req
);

  logic [`N_RBUS_ADDR_BITS-1:0] offs_full;
  logic                         above_start;
  logic                         in_window;
  logic                         in_span;
  logic                         req_hit;
  logic                         hit_err;
  logic                         err_q1;
  logic                         err_q2;
  loc_req_t                     loc_req_d;
  rbus_ring_t                   ring_d;

  // the window is [start, end]; the register span is the first eight words.
  // an address in only one of the two is claimed and answered with err_ack.
  always_comb begin
    offs_full   = i_rbus_ring.addr - i_cfg_start_addr;
    above_start = i_rbus_ring.addr >= i_cfg_start_addr;
    in_window   = above_start && (i_rbus_ring.addr <= i_cfg_end_addr);
    in_span     = above_start &&
                  (offs_full[`N_RBUS_ADDR_BITS-1:`N_LOCL_ADDR_BITS] == '0);
    req_hit     = (i_rbus_ring.wr_strb || i_rbus_ring.rd_strb) && (in_window || in_span);
    hit_err     = req_hit && !(in_window && in_span);
  end

  always_comb begin
    loc_req_d.op     = ACC_NONE;
    loc_req_d.offset = offs_full[`N_LOCL_ADDR_BITS-1:0];
    loc_req_d.wdata  = i_rbus_ring.wr_data;
    if (req_hit && !hit_err) begin
      loc_req_d.op = i_rbus_ring.wr_strb ? ACC_WRITE : ACC_READ;
    end
  end

  // local answers override the hop; upstream acks never overlap with them.
  always_comb begin
    ring_d = i_rbus_ring;
    if (i_loc_rsp.ack || i_loc_rsp.err_ack || err_q2) begin
      ring_d.ack     = i_loc_rsp.ack && !err_q2;
      ring_d.err_ack = i_loc_rsp.err_ack || err_q2;
      ring_d.rd_data = i_loc_rsp.rdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rbus_ring <= '0;
      o_loc_req   <= '0;
      err_q1      <= 1'b0;
      err_q2      <= 1'b0;
    end else begin
      o_rbus_ring <= ring_d;
      o_loc_req   <= loc_req_d;
      // match the two-cycle latency of the register file.
      err_q1      <= hit_err;
      err_q2      <= err_q1;
    end
  end

endmodule

`default_nettype wire

// ==== src/support_regs.sv ====
/*
  Support register file.
  Decodes local requests, holds spare and control words, samples bank
  availability, pulses consumed strobes and forwards interrupt accesses.
*/
`timescale 1ns/1ns
`default_nettype none

`include "cddip_support_consts.svh"

module support_regs import cddip_support_pkg::*; (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire loc_req_t                i_loc_req,
  input  wire im_flags_t               i_im_available,
  input  wire [`N_RBUS_DATA_BITS-1:0]  i_pipe_stat,
  input  wire int_rsp_t                i_int_rsp,
  output loc_rsp_t                     o_loc_rsp,
  output im_flags_t                    o_im_consumed,
  output ctl_t                         o_ctl_config,
  output int_req_t                     o_int_req
);

  logic                         is_rd;
  logic                         is_wr;
  logic                         int_sel;
  logic                         int_miss;
  logic [`N_RBUS_DATA_BITS-1:0] spare_q;
  logic [`N_RBUS_DATA_BITS-1:0] rdata_d;
  im_flags_t                    avail_q;

  always_comb begin
    is_rd    = i_loc_req.op == ACC_READ;
    is_wr    = i_loc_req.op == ACC_WRITE;
    int_sel  = (i_loc_req.offset == `REG_INT_STATUS) ||
               (i_loc_req.offset == `REG_INT_MASK);
    // the interrupt unit must answer every access routed to it.
    int_miss = int_sel && (is_rd || is_wr) && !i_int_rsp.ack;
  end

  // interrupt accesses go out in the request cycle.
  always_comb begin
    o_int_req.rd       = is_rd && int_sel;
    o_int_req.wr       = is_wr && int_sel;
    o_int_req.sel_mask = i_loc_req.offset == `REG_INT_MASK;
    o_int_req.data     = i_loc_req.wdata[`N_INT_BITS-1:0];
  end

  always_comb begin
    rdata_d = '0;
    case (i_loc_req.offset)
      `REG_BLKID_REVID:  rdata_d = {`CDDIP_BLKID, `CDDIP_REVID};
      `REG_SPARE:        rdata_d = spare_q;
      `REG_CTL:          rdata_d = o_ctl_config;
      `REG_IM_AVAILABLE: rdata_d[$bits(im_flags_t)-1:0] = avail_q;
      `REG_PIPE_STAT:    rdata_d = i_pipe_stat;
      `REG_INT_STATUS,
      `REG_INT_MASK:     rdata_d[`N_INT_BITS-1:0] = i_int_rsp.data;
      default:           rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_loc_rsp     <= '0;
      o_im_consumed <= '0;
      o_ctl_config  <= '0;
      spare_q       <= '0;
      avail_q       <= '0;
    end else begin
      avail_q           <= i_im_available;
      o_im_consumed     <= '0;
      o_loc_rsp.ack     <= (is_rd || is_wr) && !int_miss;
      o_loc_rsp.err_ack <= int_miss;
      o_loc_rsp.rdata   <= is_rd ? rdata_d : '0;
      // read-only offsets take the write and drop it.
      if (is_wr) begin
        case (i_loc_req.offset)
          `REG_SPARE:       spare_q <= i_loc_req.wdata;
          `REG_CTL:         o_ctl_config <= ctl_t'(i_loc_req.wdata);
          `REG_IM_CONSUMED: o_im_consumed <= im_flags_t'(i_loc_req.wdata[$bits(im_flags_t)-1:0]);
          default:          ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== verif/cddip_support_sva.sv ====
/*
  Protocol assertions for the decompression support top.
*/
`timescale 1ns/1ns
`default_nettype none

`include "cddip_support_consts.svh"

module cddip_support_sva import cddip_support_pkg::*; (
  input wire                     clk,
  input wire                     rst_n,
  input wire rbus_ring_t         i_ring_in,
  input wire rbus_ring_t         i_ring_out,
  input wire loc_rsp_t           i_loc_rsp,
  input wire im_flags_t          i_consumed,
  input wire [`N_INT_BITS-1:0]   i_status,
  input wire [`N_INT_BITS-1:0]   i_mask,
  input wire                     i_int
);

  a_ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(i_ring_out.ack && i_ring_out.err_ack))
    else $error("ring output carries ack and err_ack together");

  // a local answer must not land on top of an upstream ack.
  a_no_ack_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !((i_loc_rsp.ack || i_loc_rsp.err_ack) && i_ring_in.ack))
    else $error("local response collides with an upstream ack");

  a_consumed_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (i_consumed != '0) |=> (i_consumed == '0))
    else $error("consumed strobes held for more than one cycle");

  a_int_masked: assert property (@(posedge clk) disable iff (!rst_n)
    ((i_status & ~i_mask) == '0) |=> !i_int)
    else $error("interrupt raised with every status bit masked");

endmodule

bind cddip_support_top cddip_support_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .i_ring_in  (i_rbus_ring),
  .i_ring_out (o_rbus_ring),
  .i_loc_rsp  (loc_rsp),
  .i_consumed (o_im_consumed),
  .i_status   (u_event_int.status_q),
  .i_mask     (u_event_int.mask_q),
  .i_int      (o_int)
);

`default_nettype wire

// ==== verif/tb_cddip_support.sv ====
/*
  Testbench for the decompression support block.
  Table-driven ring accesses, window and pass-through checks, event interrupts.
*/
`timescale 1ns/1ns
`default_nettype none

`include "cddip_support_consts.svh"

module tb_cddip_support import cddip_support_pkg::*; ();

  typedef struct packed {
    acc_op_e     op;
    logic [15:0] addr;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } entry_t;

  localparam int N_ENT = 8;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [15:0] cfg_start;
  logic [15:0] cfg_end;
  rbus_ring_t  ring_in;
  im_flags_t   im_avail;
  logic [31:0] pipe_stat;
  int_src_t    int_src;
  rbus_ring_t  ring_out;
  im_flags_t   im_consumed;
  ctl_t        ctl_config;
  logic        int_line;
  entry_t      table_q [N_ENT];
  string       ent_name [N_ENT];
  integer      seed;
  logic [5:0]  cons_seen;
  integer      cons_cycles;

  always #2 clk = ~clk;

  cddip_support_top UUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .i_cfg_start_addr (cfg_start),
    .i_cfg_end_addr   (cfg_end),
    .i_rbus_ring      (ring_in),
    .i_im_available   (im_avail),
    .i_pipe_stat      (pipe_stat),
    .i_int_src        (int_src),
    .o_rbus_ring      (ring_out),
    .o_im_consumed    (im_consumed),
    .o_ctl_config     (ctl_config),
    .o_int            (int_line)
  );

  // collects every consumed strobe and how many cycles they were up.
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cons_seen   <= '0;
      cons_cycles <= 0;
    end else if (im_consumed != '0) begin
      cons_seen   <= cons_seen | im_consumed;
      cons_cycles <= cons_cycles + 1;
    end
  end

  task automatic abort_run();
    $display("Checks failed");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_value(input string name, input logic [127:0] exp,
                             input logic [127:0] act);
    if (exp !== act) begin
      $display("Error %s expected %0h actual %0h", name, exp, act);
      abort_run();
    end
  endtask

  // register bits 5..0 are xpd hi, xpd lo, lz77d hi, lz77d lo, htf_bl hi, htf_bl lo.
  function automatic im_flags_t flags_from_bits(input logic [5:0] bits);
    im_flags_t f;
    f.xpd.bank_hi    = bits[5];
    f.xpd.bank_lo    = bits[4];
    f.lz77d.bank_hi  = bits[3];
    f.lz77d.bank_lo  = bits[2];
    f.htf_bl.bank_hi = bits[1];
    f.htf_bl.bank_lo = bits[0];
    return f;
  endfunction

  // one request on the ring, then wait for the local ack or err_ack.
  task automatic ring_access(input string name, input acc_op_e op, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    integer waited;
    logic   done;
    @(posedge clk);
    ring_in.addr    <= addr;
    ring_in.wr_data <= wdata;
    ring_in.wr_strb <= (op == ACC_WRITE);
    ring_in.rd_strb <= (op == ACC_READ);
    @(posedge clk);
    ring_in <= '0;
    waited = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      waited = waited + 1;
      if (ring_out.ack || ring_out.err_ack) begin
        done = 1'b1;
      end else if (waited > 16) begin
        $display("no ring response arrived for %s", name);
        abort_run();
      end
    end
    check_value({name, "_latency"}, 128'(3), 128'(waited));
    rdata = ring_out.rd_data;
    err   = ring_out.err_ack;
  endtask

  // a hop that the node does not own comes out unchanged and draws no answer.
  task automatic send_hop(input string name, input rbus_ring_t hop);
    @(posedge clk);
    ring_in <= hop;
    @(posedge clk);
    ring_in <= '0;
    @(posedge clk);
    check_value(name, 128'(hop), 128'(ring_out));
    repeat (5) begin
      @(posedge clk);
      check_value({name, "_no_ack"}, 128'(0), 128'({ring_out.ack, ring_out.err_ack}));
    end
  endtask

  task automatic wait_int_level(input string name, input logic level);
    integer waited;
    waited = 0;
    while (int_line !== level) begin
      @(posedge clk);
      waited = waited + 1;
      if (waited > 16) begin
        $display("interrupt line did not reach %0b during %s", level, name);
        abort_run();
      end
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [31:0] spare_val;
    logic [31:0] ctl_val;
    logic [31:0] pipe_val;
    logic [5:0]  avail_val;
    logic [5:0]  cons_val;
    logic [31:0] rdata;
    logic        err;
    logic [14:0] ev_mask;
    integer      ev_bit;
    rbus_ring_t  hop;

    seed      = 32'h77e88b60;
    rnd       = $random(seed);
    avail_val = rnd[5:0];
    pipe_val  = $random(seed);
    spare_val = $random(seed);
    ctl_val   = $random(seed);
    rnd       = $random(seed);
    cons_val  = rnd[5:0] | 6'h01;
    rst_n     <= 1'b0;
    cfg_start <= 16'h0100;
    cfg_end   <= 16'h0107;
    ring_in   <= '0;
    im_avail  <= flags_from_bits(avail_val);
    pipe_stat <= pipe_val;
    int_src   <= '0;

    table_q[0] = '{ACC_READ, 16'h0100, 32'h0, {`CDDIP_BLKID, `CDDIP_REVID}, 1'b0};
    table_q[1] = '{ACC_WRITE, 16'h0101, spare_val, 32'h0, 1'b0};
    table_q[2] = '{ACC_READ, 16'h0101, 32'h0, spare_val, 1'b0};
    table_q[3] = '{ACC_WRITE, 16'h0102, ctl_val, 32'h0, 1'b0};
    table_q[4] = '{ACC_READ, 16'h0102, 32'h0, ctl_val, 1'b0};
    table_q[5] = '{ACC_READ, 16'h0103, 32'h0, {26'h0, avail_val}, 1'b0};
    table_q[6] = '{ACC_READ, 16'h0105, 32'h0, pipe_val, 1'b0};
    table_q[7] = '{ACC_WRITE, 16'h0104, {26'h0, cons_val}, 32'h0, 1'b0};
    ent_name   = '{"blkid_read", "spare_write", "spare_read", "ctl_write",
                   "ctl_read", "avail_read", "pipe_stat_read", "consumed_write"};

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < N_ENT; i++) begin
      ring_access(ent_name[i], table_q[i].op, table_q[i].addr, table_q[i].wdata, rdata, err);
      check_value({ent_name[i], "_err"}, 128'(table_q[i].exp_err), 128'(err));
      if (table_q[i].op == ACC_READ) begin
        check_value(ent_name[i], 128'(table_q[i].exp_rdata), 128'(rdata));
      end
    end
    check_value("ctl_config", 128'(ctl_val), 128'(ctl_config));
    check_value("consumed_bits", 128'(flags_from_bits(cons_val)), 128'(cons_seen));
    check_value("consumed_cycles", 128'(1), 128'(cons_cycles));

    hop         = '0;
    hop.addr    = 16'h0200;
    hop.rd_strb = 1'b1;
    hop.wr_data = $random(seed);
    send_hop("outside_window", hop);
    hop         = '0;
    hop.addr    = 16'h0300;
    hop.ack     = 1'b1;
    hop.rd_data = $random(seed);
    send_hop("upstream_ack", hop);

    cfg_end <= 16'h0104;
    ring_access("shrunk_window_read", ACC_READ, 16'h0106, 32'h0, rdata, err);
    check_value("shrunk_window_err", 128'(1), 128'(err));
    cfg_end <= 16'h0107;

    rnd     = $random(seed);
    ev_bit  = rnd % 32'd15;
    ev_mask = 15'd1 << ev_bit;
    @(posedge clk);
    int_src <= int_src_t'(ev_mask);
    @(posedge clk);
    int_src <= '0;
    wait_int_level("event_raise", 1'b1);
    ring_access("int_status_read", ACC_READ, 16'h0106, 32'h0, rdata, err);
    check_value("int_status_read", 128'({17'h0, ev_mask}), 128'(rdata));
    ring_access("int_mask_set", ACC_WRITE, 16'h0107, {17'h0, ev_mask}, rdata, err);
    wait_int_level("event_masked", 1'b0);
    ring_access("int_status_masked", ACC_READ, 16'h0106, 32'h0, rdata, err);
    check_value("int_status_masked", 128'({17'h0, ev_mask}), 128'(rdata));
    ring_access("int_mask_clear", ACC_WRITE, 16'h0107, 32'h0, rdata, err);
    wait_int_level("event_unmasked", 1'b1);
    ring_access("int_status_w1c", ACC_WRITE, 16'h0106, {17'h0, ev_mask}, rdata, err);
    wait_int_level("status_cleared", 1'b0);
    ring_access("int_status_clear", ACC_READ, 16'h0106, 32'h0, rdata, err);
    check_value("int_status_clear", 128'(0), 128'(rdata));

    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
